// File: hdl/rat_pkg.sv
package rat_pkg;

  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_RENAME = 3;
  localparam int NUM_RETIRE = 3;
  localparam int NUM_READ = 3;

  localparam int ARCH_REG_W = $clog2(NUM_ARCH_REGS);
  // one extra bit opens the dependency range above the registers
  localparam int READ_ADDR_W = ARCH_REG_W + 1;
  localparam int ROB_TAG_W = 9;
  localparam int FUNIT_W = 10;
  localparam int DOM_W = 2;

  // slot number sits below the two prefix bits of a dependency read
  localparam int DEP_SLOT_W = READ_ADDR_W - 2;
  localparam int SLOT_IDX_W = $clog2(NUM_RENAME);

  typedef logic [ARCH_REG_W-1:0] arch_reg_t;
  typedef logic [READ_ADDR_W-1:0] read_addr_t;
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;
  typedef logic [FUNIT_W-1:0] funit_t;
  typedef logic [DOM_W-1:0] dom_t;

  localparam logic [1:0] DEP_PREFIX = 2'b11;
  localparam funit_t RESET_FUNIT = {1'b1, {(FUNIT_W-1){1'b0}}};

  typedef struct packed {
    logic      wen;
    arch_reg_t areg;
    rob_tag_t  tag;
    funit_t    funit;
    dom_t      dom;
  } rename_req_t;

  // tag selects the entry to retire, areg the entry whose pending domain is loaded
  typedef struct packed {
    logic      wen;
    rob_tag_t  tag;
    arch_reg_t areg;
    dom_t      dom;
  } retire_req_t;

  typedef struct packed {
    rob_tag_t tag;
    logic     retired;
    funit_t   funit;
    dom_t     dom;
  } map_entry_t;

  typedef struct packed {
    map_entry_t map;
    logic       is_dep;
  } read_rsp_t;

  // state of every entry after reset
  localparam map_entry_t RESET_ENTRY = '{
    tag:     '0,
    retired: 1'b1,
    funit:   RESET_FUNIT,
    dom:     '0
  };

  localparam dom_t RESET_PEND_DOM = '0;

endpackage

// File: hdl/rat_entry.sv
`timescale 1ns/1ps

module rat_entry #(
  parameter int ENTRY_INDEX = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clk_en,
  input  rat_pkg::rename_req_t rename [rat_pkg::NUM_RENAME],
  input  rat_pkg::retire_req_t retire [rat_pkg::NUM_RETIRE],
  input  logic                 retire_all,
  output rat_pkg::map_entry_t  entry
);

  import rat_pkg::*;

  localparam arch_reg_t MY_REG = arch_reg_t'(ENTRY_INDEX);

  map_entry_t state_q;
  map_entry_t state_d;
  dom_t       pend_dom_q;
  dom_t       pend_dom_d;

  logic [NUM_RENAME-1:0] ren_hit;
  logic [NUM_RETIRE-1:0] ret_hit;
  logic [NUM_RETIRE-1:0] pend_hit;
  logic                  ren_any;
  logic                  ret_any;
  rename_req_t           ren_win;

  // renames are frozen with clk_en low, retires are not
  always_comb
  begin
    for (int i = 0; i < NUM_RENAME; i++)
    begin
      ren_hit[i] = rename[i].wen && clk_en && (rename[i].areg == MY_REG);
    end
    for (int j = 0; j < NUM_RETIRE; j++)
    begin
      ret_hit[j] = retire[j].wen && (retire[j].tag == state_q.tag);
      pend_hit[j] = retire[j].wen && (retire[j].areg == MY_REG);
    end
  end

  assign ren_any = |ren_hit;
  assign ret_any = |ret_hit;

  // later slots overwrite earlier ones, so the highest slot wins
  always_comb
  begin
    ren_win = '0;
    for (int i = 0; i < NUM_RENAME; i++)
    begin
      if (ren_hit[i])
      begin
        ren_win = rename[i];
      end
    end
  end

  always_comb
  begin
    pend_dom_d = pend_dom_q;
    for (int j = 0; j < NUM_RETIRE; j++)
    begin
      if (pend_hit[j])
      begin
        pend_dom_d = retire[j].dom;
      end
    end
  end

  always_comb
  begin
    state_d = state_q;
    if (ren_any)
    begin
      state_d.tag = ren_win.tag;
      state_d.funit = ren_win.funit;
      state_d.dom = ren_win.dom;
      state_d.retired = 1'b0;
    end
    else if (ret_any)
    begin
      // a rename of the same register in this cycle keeps it live
      state_d.retired = 1'b1;
    end
    // flush commits the pending domain, tag and funit still follow rename
    if (retire_all)
    begin
      state_d.dom = pend_dom_q;
      state_d.retired = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= RESET_ENTRY;
      pend_dom_q <= RESET_PEND_DOM;
    end
    else
    begin
      state_q <= state_d;
      pend_dom_q <= pend_dom_d;
    end
  end

  assign entry = state_q;

endmodule

// File: hdl/rat_read_port.sv
`timescale 1ns/1ps

module rat_read_port (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clk_en,
  input  rat_pkg::read_addr_t  read_addr [rat_pkg::NUM_READ],
  input  rat_pkg::map_entry_t  map_table [rat_pkg::NUM_ARCH_REGS],
  input  rat_pkg::rename_req_t rename [rat_pkg::NUM_RENAME],
  output rat_pkg::read_rsp_t   read_rsp [rat_pkg::NUM_READ]
);

  import rat_pkg::*;

  read_addr_t addr_q [NUM_READ];

  // address stage only, table data stays combinational
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < NUM_READ; p++)
      begin
        addr_q[p] <= '0;
      end
    end
    else if (clk_en)
    begin
      addr_q <= read_addr;
    end
  end

  generate
    for (genvar p = 0; p < NUM_READ; p++)
    begin : g_port
      logic                  addr_is_reg;
      logic                  addr_is_dep;
      logic [DEP_SLOT_W-1:0] slot;
      logic                  slot_valid;
      arch_reg_t             reg_idx;
      rename_req_t           fwd;
      read_rsp_t             rsp;

      // 0..31 name a register, prefix 11 names a rename slot
      assign addr_is_reg = (addr_q[p][READ_ADDR_W-1] == 1'b0);
      assign addr_is_dep = (addr_q[p][READ_ADDR_W-1 -: 2] == DEP_PREFIX);
      assign reg_idx = addr_q[p][ARCH_REG_W-1:0];
      assign slot = addr_q[p][DEP_SLOT_W-1:0];
      assign slot_valid = (slot < DEP_SLOT_W'(NUM_RENAME));

      // slot numbers past the last rename slot forward nothing
      assign fwd = slot_valid ? rename[slot[SLOT_IDX_W-1:0]] : '0;

      // register range first, then dependency range, else zeros
      always_comb
      begin
        rsp = '0;
        if (addr_is_reg)
        begin
          rsp.map = map_table[reg_idx];
        end
        else if (addr_is_dep)
        begin
          rsp.map.tag = fwd.tag;
          rsp.map.funit = fwd.funit;
          rsp.map.dom = fwd.dom;
          rsp.map.retired = 1'b0;
          rsp.is_dep = 1'b1;
        end
      end

      assign read_rsp[p] = rsp;
    end
  endgenerate

endmodule

// File: hdl/rat_top.sv
`timescale 1ns/1ps

module rat_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clk_en,
  input  rat_pkg::rename_req_t rename [rat_pkg::NUM_RENAME],
  input  rat_pkg::retire_req_t retire [rat_pkg::NUM_RETIRE],
  input  logic                 retire_all,
  input  rat_pkg::read_addr_t  read_addr [rat_pkg::NUM_READ],
  output rat_pkg::read_rsp_t   read_rsp [rat_pkg::NUM_READ]
);

  import rat_pkg::*;

  // current mapping of every architectural register
  map_entry_t map_table [NUM_ARCH_REGS];

  generate
    for (genvar r = 0; r < NUM_ARCH_REGS; r++)
    begin : g_entry
      rat_entry #(
        .ENTRY_INDEX (r)
      ) i_entry (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .rename     (rename),
        .retire     (retire),
        .retire_all (retire_all),
        .entry      (map_table[r])
      );
    end
  endgenerate

  // all read ports share one address stage and forwarding mux
  rat_read_port i_read_port (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .read_addr (read_addr),
    .map_table (map_table),
    .rename    (rename),
    .read_rsp  (read_rsp)
  );

endmodule

// File: testbench/rat_chk.sv
`timescale 1ns/1ps

module rat_chk (
  input logic                clk,
  input logic                rst,
  input logic                clk_en,
  input logic                retire_all,
  input rat_pkg::read_addr_t read_addr [rat_pkg::NUM_READ],
  input rat_pkg::read_rsp_t  read_rsp [rat_pkg::NUM_READ]
);

  import rat_pkg::*;

  generate
    for (genvar p = 0; p < NUM_READ; p++)
    begin : g_port
      // address sampled at this edge shapes the response up to the next one
      dep_sets_is_dep: assert property (@(posedge clk) disable iff (rst)
        (clk_en && (read_addr[p][READ_ADDR_W-1 -: 2] == DEP_PREFIX)) |=> read_rsp[p].is_dep)
      else $error("port %0d: dependency read came back without is_dep", p);

      flush_sets_retired: assert property (@(posedge clk) disable iff (rst)
        (clk_en && retire_all && (read_addr[p][READ_ADDR_W-1 -: 2] != 2'b10))
        |=> (read_rsp[p].map.retired || read_rsp[p].is_dep))
      else $error("port %0d: entry not retired after retire_all", p);

      unused_reads_zero: assert property (@(posedge clk) disable iff (rst)
        (clk_en && (read_addr[p][READ_ADDR_W-1 -: 2] == 2'b10)) |=> (read_rsp[p] == '0))
      else $error("port %0d: unused address gave a nonzero response", p);
    end
  endgenerate

endmodule

bind rat_top rat_chk i_chk (
  .clk        (clk),
  .rst        (rst),
  .clk_en     (clk_en),
  .retire_all (retire_all),
  .read_addr  (read_addr),
  .read_rsp   (read_rsp)
);

// File: testbench/rat_model.svh
`ifndef RAT_MODEL_SVH
`define RAT_MODEL_SVH

// reference copy of the table, pending domains and sampled read addresses
map_entry_t m_table [NUM_ARCH_REGS];
dom_t       m_pend [NUM_ARCH_REGS];
read_addr_t m_addr [NUM_READ];
string      m_kind;

function automatic void model_reset();
  for (int r = 0; r < NUM_ARCH_REGS; r++)
  begin
    m_table[r].tag = '0;
    m_table[r].retired = 1'b1;
    m_table[r].funit = RESET_FUNIT;
    m_table[r].dom = '0;
    m_pend[r] = '0;
  end
  for (int p = 0; p < NUM_READ; p++)
  begin
    m_addr[p] = '0;
  end
  m_kind = "reset_state";
endfunction

// applies the inputs that are present at a rising edge
function automatic void model_step(input string kind);
  map_entry_t nxt [NUM_ARCH_REGS];
  dom_t       pend_nxt [NUM_ARCH_REGS];
  int         win;
  logic       ret_hit;
  for (int r = 0; r < NUM_ARCH_REGS; r++)
  begin
    nxt[r] = m_table[r];
    pend_nxt[r] = m_pend[r];
    win = -1;
    ret_hit = 1'b0;
    for (int i = 0; i < NUM_RENAME; i++)
    begin
      if (clk_en && rename[i].wen && rename[i].areg == arch_reg_t'(r))
        win = i;
    end
    for (int j = 0; j < NUM_RETIRE; j++)
    begin
      if (retire[j].wen && retire[j].tag == m_table[r].tag)
        ret_hit = 1'b1;
      if (retire[j].wen && retire[j].areg == arch_reg_t'(r))
        pend_nxt[r] = retire[j].dom;
    end
    if (win >= 0)
    begin
      nxt[r].tag = rename[win].tag;
      nxt[r].funit = rename[win].funit;
      nxt[r].dom = rename[win].dom;
      nxt[r].retired = 1'b0;
    end
    else if (ret_hit)
      nxt[r].retired = 1'b1;
    // flush takes the pending domain from before this edge
    if (retire_all)
    begin
      nxt[r].dom = m_pend[r];
      nxt[r].retired = 1'b1;
    end
  end
  m_table = nxt;
  m_pend = pend_nxt;
  if (clk_en)
    m_addr = read_addr;
  m_kind = kind;
endfunction

function automatic read_rsp_t expected_rsp(input int p);
  read_rsp_t  rsp;
  read_addr_t a;
  int         slot;
  a = m_addr[p];
  rsp = '0;
  if (a[READ_ADDR_W-1] == 1'b0)
    rsp.map = m_table[a[ARCH_REG_W-1:0]];
  else if (a[READ_ADDR_W-1 -: 2] == DEP_PREFIX)
  begin
    slot = int'(a[DEP_SLOT_W-1:0]);
    rsp.is_dep = 1'b1;
    // live slot inputs, whatever their wen
    if (slot < NUM_RENAME)
    begin
      rsp.map.tag = rename[slot].tag;
      rsp.map.funit = rename[slot].funit;
      rsp.map.dom = rename[slot].dom;
    end
  end
  return rsp;
endfunction

function automatic string behavior_name(input int p);
  if (m_addr[p][READ_ADDR_W-1 -: 2] == DEP_PREFIX)
    return "dep_forward";
  if (m_addr[p][READ_ADDR_W-1] == 1'b1)
    return "unused_addr";
  return m_kind;
endfunction

`endif

// File: testbench/tb_rat.sv
`timescale 1ns/1ps

module tb_rat;

  import rat_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_CYCLES = 3000;
  localparam int SWEEP_CYCLES = (NUM_ARCH_REGS + NUM_READ - 1) / NUM_READ + 1;
  localparam int TIMEOUT_NS = (NUM_CYCLES + RESET_CYCLES) * CLK_PERIOD + 20 * CLK_PERIOD;
  localparam int DRIVE_DELAY = 1;
  localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - DRIVE_DELAY;
  localparam logic [31:0] SEED = 32'h9697_e5b5;

  logic        clk;
  logic        rst;
  logic        clk_en;
  logic        retire_all;
  rename_req_t rename [NUM_RENAME];
  retire_req_t retire [NUM_RETIRE];
  read_addr_t  read_addr [NUM_READ];
  read_rsp_t   read_rsp [NUM_READ];
  int          errors;
  string       drive_kind;

  `include "rat_model.svh"

  rat_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .clk_en     (clk_en),
    .rename     (rename),
    .retire     (retire),
    .retire_all (retire_all),
    .read_addr  (read_addr),
    .read_rsp   (read_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("error: run timed out after %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

  // half the picks land on registers 0..3 so slots and ports collide
  function automatic arch_reg_t hot_reg();
    if ($urandom_range(1) == 0)
      return arch_reg_t'($urandom_range(3));
    return arch_reg_t'($urandom_range(NUM_ARCH_REGS - 1));
  endfunction

  function automatic read_addr_t random_addr();
    int roll;
    roll = $urandom_range(99);
    if (roll < 55)
      return read_addr_t'(hot_reg());
    // slots past the last rename slot are included
    if (roll < 80)
      return {DEP_PREFIX, DEP_SLOT_W'($urandom_range(NUM_RENAME + 1))};
    if (roll < 90)
      return {2'b10, DEP_SLOT_W'($urandom())};
    return read_addr_t'($urandom());
  endfunction

  task automatic set_idle();
    clk_en = 1'b0;
    retire_all = 1'b0;
    for (int i = 0; i < NUM_RENAME; i++)
      rename[i] = '0;
    for (int j = 0; j < NUM_RETIRE; j++)
      retire[j] = '0;
    for (int p = 0; p < NUM_READ; p++)
      read_addr[p] = '0;
  endtask

  // walks every register with no writes to read back the reset state
  task automatic drive_sweep(input int c);
    set_idle();
    clk_en = 1'b1;
    for (int p = 0; p < NUM_READ; p++)
    begin
      if (c * NUM_READ + p < NUM_ARCH_REGS)
        read_addr[p] = read_addr_t'(c * NUM_READ + p);
    end
    drive_kind = "reset_state";
  endtask

  task automatic drive_random();
    clk_en = ($urandom_range(99) >= 20);
    retire_all = ($urandom_range(99) < 3);
    for (int i = 0; i < NUM_RENAME; i++)
    begin
      rename[i].wen = ($urandom_range(99) < 60);
      rename[i].areg = hot_reg();
      rename[i].tag = rob_tag_t'($urandom());
      rename[i].funit = funit_t'($urandom());
      rename[i].dom = dom_t'($urandom());
    end
    // most retire tags come from live mappings so they can hit
    for (int j = 0; j < NUM_RETIRE; j++)
    begin
      retire[j].wen = ($urandom_range(99) < 50);
      retire[j].tag = ($urandom_range(99) < 70) ? m_table[hot_reg()].tag
                                                 : rob_tag_t'($urandom());
      retire[j].areg = hot_reg();
      retire[j].dom = dom_t'($urandom());
    end
    for (int p = 0; p < NUM_READ; p++)
      read_addr[p] = random_addr();
    if (!clk_en)
      drive_kind = "clk_en_hold";
    else if (retire_all)
      drive_kind = "retire_all";
    else
      drive_kind = "rename_retire";
  endtask

  task automatic check_responses();
    read_rsp_t exp;
    for (int p = 0; p < NUM_READ; p++)
    begin
      exp = expected_rsp(p);
      assert (read_rsp[p] === exp)
      else
      begin
        errors++;
        $display("Mismatch %s port %0d: expected %h, actual %h",
                 behavior_name(p), p, exp, read_rsp[p]);
      end
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    errors = 0;
    rst = 1'b1;
    set_idle();
    drive_kind = "reset_state";
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      @(posedge clk);
      model_step(drive_kind);
      #(DRIVE_DELAY);
      if (c < SWEEP_CYCLES - 1)
        drive_sweep(c);
      else
        drive_random();
      // mid cycle, after the new inputs have settled
      #(SAMPLE_DELAY);
      check_responses();
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+testbench
hdl/rat_pkg.sv
hdl/rat_entry.sv
hdl/rat_read_port.sv
hdl/rat_top.sv
testbench/rat_chk.sv
testbench/tb_rat.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_rat -f tb.f -o tb_rat
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/tb_rat)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
